// File: hdl/mem_sys_pkg.sv
//**************************************************
// Shared definitions for the two-client memory system
// Address split, memory timing and FSM encodings
// Modules import this inside their bodies
//**************************************************
`default_nettype none

package mem_sys_pkg;

   // Byte address and word width
   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 16;

   // Address split is tag | index | offset
   localparam int TAG_W      = 5;
   localparam int INDEX_W    = 8;
   localparam int OFFSET_W   = 3;
   localparam int LINE_WORDS = 4;

   // Cycles a bank stays busy once it takes an access
   localparam int BANK_BUSY  = 4;
   // Accept to valid data_out
   localparam int MEM_RD_LAT = 2;

   // Cache controller FSM
   typedef enum logic [3:0] {
      ERR        = 4'd0,
      IDLE       = 4'd1,
      COMPRD     = 4'd2,
      COMPWR     = 4'd3,
      PREWB      = 4'd4,
      WBMEM      = 4'd5,
      MEMRD      = 4'd6,
      MEMWAIT    = 4'd7,
      INSTALL    = 4'd8,
      DONE       = 4'd9,
      WRMISSDONE = 4'd10
   } ctrl_state_e;

   // Memory owner seen by the arbiter
   typedef enum logic {
      CLIENT_A = 1'b0,
      CLIENT_B = 1'b1
   } client_e;

endpackage

`default_nettype wire

// File: hdl/cache_array.sv
//**************************************************
// Storage for one direct-mapped cache
// Tag, valid, dirty and four data words per line
// Reads are combinational, writes land at the clock edge
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module cache_array (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            enable,
   input  wire                            comp,
   input  wire                            write,
   input  wire                            valid_in,
   input  wire [mem_sys_pkg::INDEX_W-1:0] index,
   input  wire [mem_sys_pkg::TAG_W-1:0]   tag_in,
   input  wire [1:0]                      word,
   input  wire [mem_sys_pkg::DATA_W-1:0]  data_in,
   output logic [mem_sys_pkg::TAG_W-1:0]  tag_out,
   output logic [mem_sys_pkg::DATA_W-1:0] data_out,
   output logic                           hit,
   output logic                           dirty,
   output logic                           valid
);
   import mem_sys_pkg::*;

   localparam int LINES = 1 << INDEX_W;

   logic [TAG_W-1:0]  tag_mem  [LINES];
   logic [DATA_W-1:0] data_mem [LINES*LINE_WORDS];
   logic [LINES-1:0]  valid_q;
   logic [LINES-1:0]  dirty_q;
   logic              tag_match;
   logic              wr_en;

   // Line lookup
   assign tag_out   = tag_mem[index];
   assign data_out  = data_mem[{index, word}];
   assign valid     = valid_q[index];
   assign dirty     = dirty_q[index];
   assign tag_match = (tag_out == tag_in);
   assign hit       = enable && comp && valid && tag_match;

   // Compare write only on a hit, install write always
   assign wr_en = enable && write && (!comp || hit);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[{index, word}] <= data_in;
         // Install also retags the line
         if (!comp) begin
            tag_mem[index] <= tag_in;
         end
      end
   end

   // Line state bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (comp) begin
            dirty_q[index] <= 1'b1;
         end else begin
            valid_q[index] <= valid_in;
            dirty_q[index] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
//**************************************************
// Write-back cache controller for one client port
// Runs hits, line fills, victim write-backs and errors
// Pairs with one cache_array and one arbiter port
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  wire                             clk,
   input  wire                             rst_n,
   // Client side
   input  wire [mem_sys_pkg::ADDR_W-1:0]   addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]   data_in,
   input  wire                             rd,
   input  wire                             wr,
   output logic [mem_sys_pkg::DATA_W-1:0]  data_out,
   output logic                            done,
   output logic                            stall,
   output logic                            cache_hit,
   output logic                            err,
   // Cache array
   output logic                            arr_enable,
   output logic                            arr_comp,
   output logic                            arr_write,
   output logic                            arr_valid_in,
   output logic [mem_sys_pkg::INDEX_W-1:0] arr_index,
   output logic [mem_sys_pkg::TAG_W-1:0]   arr_tag_in,
   output logic [1:0]                      arr_word,
   output logic [mem_sys_pkg::DATA_W-1:0]  arr_data_in,
   input  wire [mem_sys_pkg::TAG_W-1:0]    arr_tag_out,
   input  wire [mem_sys_pkg::DATA_W-1:0]   arr_data_out,
   input  wire                             arr_hit,
   input  wire                             arr_dirty,
   input  wire                             arr_valid,
   // Arbiter port
   output logic                            mem_req,
   output logic                            mem_rd,
   output logic                            mem_wr,
   output logic [mem_sys_pkg::ADDR_W-1:0]  mem_addr,
   output logic [mem_sys_pkg::DATA_W-1:0]  mem_wdata,
   input  wire [mem_sys_pkg::DATA_W-1:0]   mem_rdata,
   input  wire                             mem_stall
);
   import mem_sys_pkg::*;

   localparam logic [1:0] LAST_WORD = 2'(LINE_WORDS - 1);

   ctrl_state_e           state_q;
   ctrl_state_e           state_d;
   // Word being written back or requested
   logic [1:0]            cnt_q;
   logic                  hit_q;
   // Fill words in flight, in step with the memory read pipeline
   logic [MEM_RD_LAT-1:0] fill_vld_q;
   logic [1:0]            fill_word_q [MEM_RD_LAT];
   logic                  rd_accept;
   logic                  wr_accept;
   logic                  install;
   logic [TAG_W-1:0]      req_tag;
   logic [INDEX_W-1:0]    req_index;
   logic [1:0]            req_word;

   // Request address split
   assign req_tag   = addr[ADDR_W-1 -: TAG_W];
   assign req_index = addr[OFFSET_W +: INDEX_W];
   assign req_word  = addr[OFFSET_W-1:1];

   assign rd_accept = mem_rd && !mem_stall;
   assign wr_accept = mem_wr && !mem_stall;
   assign install   = fill_vld_q[MEM_RD_LAT-1];

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (rd && wr) begin
               state_d = ERR;
            end else if (rd) begin
               state_d = COMPRD;
            end else if (wr) begin
               state_d = COMPWR;
            end
         end
         COMPRD, COMPWR: begin
            if (arr_hit) begin
               state_d = DONE;
            end else if (arr_valid && arr_dirty) begin
               state_d = PREWB;
            end else begin
               state_d = MEMRD;
            end
         end
         // Wait here for the grant
         PREWB: begin
            if (!mem_stall) begin
               state_d = WBMEM;
            end
         end
         WBMEM: begin
            if (wr_accept && cnt_q == LAST_WORD) begin
               state_d = MEMRD;
            end
         end
         MEMRD: begin
            if (rd_accept && cnt_q == LAST_WORD) begin
               state_d = MEMWAIT;
            end
         end
         // Last word returns next cycle
         MEMWAIT: begin
            if (fill_vld_q[MEM_RD_LAT-2] && fill_word_q[MEM_RD_LAT-2] == LAST_WORD) begin
               state_d = INSTALL;
            end
         end
         INSTALL:          state_d = wr ? WRMISSDONE : DONE;
         DONE, WRMISSDONE: state_d = IDLE;
         default:          state_d = ERR;
      endcase
   end

   // Array and memory controls
   always_comb begin
      arr_enable   = 1'b0;
      arr_comp     = 1'b0;
      arr_write    = 1'b0;
      arr_valid_in = 1'b0;
      arr_word     = req_word;
      arr_data_in  = data_in;
      mem_rd       = 1'b0;
      mem_wr       = 1'b0;
      case (state_q)
         COMPRD: begin
            arr_enable = 1'b1;
            arr_comp   = 1'b1;
         end
         // Write hit, or the write that finishes a write miss
         COMPWR, WRMISSDONE: begin
            arr_enable = 1'b1;
            arr_comp   = 1'b1;
            arr_write  = 1'b1;
         end
         WBMEM: begin
            arr_word = cnt_q;
            mem_wr   = 1'b1;
         end
         MEMRD:   mem_rd = 1'b1;
         default: ;
      endcase
      // A returning fill word goes straight into the line
      if (install) begin
         arr_enable   = 1'b1;
         arr_write    = 1'b1;
         arr_valid_in = 1'b1;
         arr_word     = fill_word_q[MEM_RD_LAT-1];
         arr_data_in  = mem_rdata;
      end
   end

   assign arr_index  = req_index;
   assign arr_tag_in = req_tag;

   // Grant is held across the write-back and the fill
   assign mem_req   = (state_q inside {PREWB, WBMEM, MEMRD, MEMWAIT, INSTALL});
   // Victim tag on write-back, request tag on fill
   assign mem_addr  = (state_q == WBMEM) ? {arr_tag_out, req_index, cnt_q, 1'b0}
                                         : {req_tag, req_index, cnt_q, 1'b0};
   assign mem_wdata = arr_data_out;

   assign data_out  = arr_data_out;
   assign done      = (state_q == DONE) || (state_q == WRMISSDONE);
   assign stall     = (state_q != IDLE) && (state_q != ERR);
   assign err       = (state_q == ERR);
   assign cache_hit = done && hit_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= IDLE;
         cnt_q      <= '0;
         hit_q      <= 1'b0;
         fill_vld_q <= '0;
      end else begin
         state_q <= state_d;
         // Wraps to zero after each burst
         if (rd_accept || wr_accept) begin
            cnt_q <= cnt_q + 2'd1;
         end
         if (state_q == COMPRD || state_q == COMPWR) begin
            hit_q <= arr_hit;
         end
         fill_vld_q <= {fill_vld_q[MEM_RD_LAT-2:0], rd_accept};
      end
   end

   always_ff @(posedge clk) begin
      fill_word_q[0] <= cnt_q;
      for (int i = 1; i < MEM_RD_LAT; i++) begin
         fill_word_q[i] <= fill_word_q[i-1];
      end
   end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
//**************************************************
// Round-robin arbiter in front of the shared memory
// A grant is held until that client drops mem_req
// Read data is broadcast, only the owner takes it
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
   input  wire                            clk,
   input  wire                            rst_n,
   // Client A
   input  wire                            a_mem_req,
   input  wire                            a_mem_rd,
   input  wire                            a_mem_wr,
   input  wire [mem_sys_pkg::ADDR_W-1:0]  a_mem_addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]  a_mem_wdata,
   output logic                           a_mem_stall,
   output logic [mem_sys_pkg::DATA_W-1:0] a_mem_rdata,
   // Client B
   input  wire                            b_mem_req,
   input  wire                            b_mem_rd,
   input  wire                            b_mem_wr,
   input  wire [mem_sys_pkg::ADDR_W-1:0]  b_mem_addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]  b_mem_wdata,
   output logic                           b_mem_stall,
   output logic [mem_sys_pkg::DATA_W-1:0] b_mem_rdata,
   // Memory side
   output logic                           rd,
   output logic                           wr,
   output logic [mem_sys_pkg::ADDR_W-1:0] addr,
   output logic [mem_sys_pkg::DATA_W-1:0] data_in,
   input  wire [mem_sys_pkg::DATA_W-1:0]  data_out,
   input  wire                            stall
);
   import mem_sys_pkg::*;

   client_e owner_q;
   client_e gnt;
   // Owner still in its burst
   logic    locked_q;
   logic    gnt_vld;
   logic    sel_a;
   logic    sel_b;

   always_comb begin
      gnt     = owner_q;
      gnt_vld = 1'b1;
      if (locked_q && ((owner_q == CLIENT_A) ? a_mem_req : b_mem_req)) begin
         gnt = owner_q;
      end else if (a_mem_req && b_mem_req) begin
         // Tie goes to whoever did not own it last
         gnt = (owner_q == CLIENT_A) ? CLIENT_B : CLIENT_A;
      end else if (a_mem_req) begin
         gnt = CLIENT_A;
      end else if (b_mem_req) begin
         gnt = CLIENT_B;
      end else begin
         gnt_vld = 1'b0;
      end
   end

   assign sel_a = gnt_vld && (gnt == CLIENT_A);
   assign sel_b = gnt_vld && (gnt == CLIENT_B);

   // Steer the owner onto the memory
   assign rd      = sel_a ? a_mem_rd : (sel_b && b_mem_rd);
   assign wr      = sel_a ? a_mem_wr : (sel_b && b_mem_wr);
   assign addr    = sel_a ? a_mem_addr : b_mem_addr;
   assign data_in = sel_a ? a_mem_wdata : b_mem_wdata;

   assign a_mem_stall = !sel_a || stall;
   assign b_mem_stall = !sel_b || stall;
   assign a_mem_rdata = data_out;
   assign b_mem_rdata = data_out;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q  <= CLIENT_B;
         locked_q <= 1'b0;
      end else begin
         locked_q <= gnt_vld;
         if (gnt_vld) begin
            owner_q <= gnt;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/four_bank_mem.sv
//**************************************************
// Main memory of four word-interleaved banks
// Address bits 2:1 pick the bank, each bank has a busy time
// Reads return MEM_RD_LAT cycles after acceptance
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module four_bank_mem (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            rd,
   input  wire                            wr,
   input  wire [mem_sys_pkg::ADDR_W-1:0]  addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]  data_in,
   output logic [mem_sys_pkg::DATA_W-1:0] data_out,
   output logic                           stall
);
   import mem_sys_pkg::*;

   localparam int BANKS = 4;
   // 8K words per bank
   localparam int ROW_W = ADDR_W - 3;
   localparam int DEPTH = BANKS * (1 << ROW_W);
   localparam int CNT_W = $clog2(BANK_BUSY + 1);

   logic [DATA_W-1:0] mem_q     [DEPTH];
   logic [CNT_W-1:0]  busy_q    [BANKS];
   logic [DATA_W-1:0] rd_pipe_q [MEM_RD_LAT];
   logic [1:0]        bank;
   logic [ROW_W-1:0]  row;
   logic              accept;

   assign bank     = addr[2:1];
   assign row      = addr[ADDR_W-1:3];
   // Only an access to a busy bank stalls
   assign stall    = (rd || wr) && (busy_q[bank] != '0);
   assign accept   = (rd || wr) && !stall;
   assign data_out = rd_pipe_q[MEM_RD_LAT-1];

   // Memory starts out all zero
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem_q[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (accept && wr) begin
         mem_q[{bank, row}] <= data_in;
      end
   end

   // Read return pipeline
   always_ff @(posedge clk) begin
      if (accept && rd) begin
         rd_pipe_q[0] <= mem_q[{bank, row}];
      end
      for (int s = 1; s < MEM_RD_LAT; s++) begin
         rd_pipe_q[s] <= rd_pipe_q[s-1];
      end
   end

   // Per-bank busy countdown
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if (accept && bank == 2'(b)) begin
               busy_q[b] <= CNT_W'(BANK_BUSY);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/mem_system_top.sv
//**************************************************
// Two-client memory system top level
// Two cache pairs share the banked memory via the arbiter
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_system_top (
   input  wire                            clk,
   input  wire                            rst_n,
   // Client A
   input  wire [mem_sys_pkg::ADDR_W-1:0]  a_addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]  a_data_in,
   input  wire                            a_rd,
   input  wire                            a_wr,
   output logic [mem_sys_pkg::DATA_W-1:0] a_data_out,
   output logic                           a_done,
   output logic                           a_stall,
   output logic                           a_cache_hit,
   output logic                           a_err,
   // Client B
   input  wire [mem_sys_pkg::ADDR_W-1:0]  b_addr,
   input  wire [mem_sys_pkg::DATA_W-1:0]  b_data_in,
   input  wire                            b_rd,
   input  wire                            b_wr,
   output logic [mem_sys_pkg::DATA_W-1:0] b_data_out,
   output logic                           b_done,
   output logic                           b_stall,
   output logic                           b_cache_hit,
   output logic                           b_err
);
   import mem_sys_pkg::*;

   // Controller to array
   logic               a_arr_enable, a_arr_comp, a_arr_write, a_arr_valid_in;
   logic               b_arr_enable, b_arr_comp, b_arr_write, b_arr_valid_in;
   logic               a_arr_hit, a_arr_dirty, a_arr_valid;
   logic               b_arr_hit, b_arr_dirty, b_arr_valid;
   logic [INDEX_W-1:0] a_arr_index, b_arr_index;
   logic [TAG_W-1:0]   a_arr_tag_in, b_arr_tag_in, a_arr_tag_out, b_arr_tag_out;
   logic [1:0]         a_arr_word, b_arr_word;
   logic [DATA_W-1:0]  a_arr_data_in, b_arr_data_in, a_arr_data_out, b_arr_data_out;
   // Controller to arbiter
   logic               a_mem_req, a_mem_rd, a_mem_wr, a_mem_stall;
   logic               b_mem_req, b_mem_rd, b_mem_wr, b_mem_stall;
   logic [ADDR_W-1:0]  a_mem_addr, b_mem_addr;
   logic [DATA_W-1:0]  a_mem_wdata, b_mem_wdata, a_mem_rdata, b_mem_rdata;
   // Arbiter to memory
   logic               mem_rd, mem_wr, mem_stall;
   logic [ADDR_W-1:0]  mem_addr;
   logic [DATA_W-1:0]  mem_wdata, mem_rdata;

   cache_array i_cache_a (
      .clk(clk), .rst_n(rst_n), .enable(a_arr_enable), .comp(a_arr_comp),
      .write(a_arr_write), .valid_in(a_arr_valid_in), .index(a_arr_index),
      .tag_in(a_arr_tag_in), .word(a_arr_word), .data_in(a_arr_data_in),
      .tag_out(a_arr_tag_out), .data_out(a_arr_data_out), .hit(a_arr_hit),
      .dirty(a_arr_dirty), .valid(a_arr_valid)
   );

   cache_ctrl i_ctrl_a (
      .clk(clk), .rst_n(rst_n), .addr(a_addr), .data_in(a_data_in), .rd(a_rd), .wr(a_wr),
      .data_out(a_data_out), .done(a_done), .stall(a_stall), .cache_hit(a_cache_hit),
      .err(a_err), .arr_enable(a_arr_enable), .arr_comp(a_arr_comp),
      .arr_write(a_arr_write), .arr_valid_in(a_arr_valid_in), .arr_index(a_arr_index),
      .arr_tag_in(a_arr_tag_in), .arr_word(a_arr_word), .arr_data_in(a_arr_data_in),
      .arr_tag_out(a_arr_tag_out), .arr_data_out(a_arr_data_out), .arr_hit(a_arr_hit),
      .arr_dirty(a_arr_dirty), .arr_valid(a_arr_valid), .mem_req(a_mem_req),
      .mem_rd(a_mem_rd), .mem_wr(a_mem_wr), .mem_addr(a_mem_addr),
      .mem_wdata(a_mem_wdata), .mem_rdata(a_mem_rdata), .mem_stall(a_mem_stall)
   );

   cache_array i_cache_b (
      .clk(clk), .rst_n(rst_n), .enable(b_arr_enable), .comp(b_arr_comp),
      .write(b_arr_write), .valid_in(b_arr_valid_in), .index(b_arr_index),
      .tag_in(b_arr_tag_in), .word(b_arr_word), .data_in(b_arr_data_in),
      .tag_out(b_arr_tag_out), .data_out(b_arr_data_out), .hit(b_arr_hit),
      .dirty(b_arr_dirty), .valid(b_arr_valid)
   );

   cache_ctrl i_ctrl_b (
      .clk(clk), .rst_n(rst_n), .addr(b_addr), .data_in(b_data_in), .rd(b_rd), .wr(b_wr),
      .data_out(b_data_out), .done(b_done), .stall(b_stall), .cache_hit(b_cache_hit),
      .err(b_err), .arr_enable(b_arr_enable), .arr_comp(b_arr_comp),
      .arr_write(b_arr_write), .arr_valid_in(b_arr_valid_in), .arr_index(b_arr_index),
      .arr_tag_in(b_arr_tag_in), .arr_word(b_arr_word), .arr_data_in(b_arr_data_in),
      .arr_tag_out(b_arr_tag_out), .arr_data_out(b_arr_data_out), .arr_hit(b_arr_hit),
      .arr_dirty(b_arr_dirty), .arr_valid(b_arr_valid), .mem_req(b_mem_req),
      .mem_rd(b_mem_rd), .mem_wr(b_mem_wr), .mem_addr(b_mem_addr),
      .mem_wdata(b_mem_wdata), .mem_rdata(b_mem_rdata), .mem_stall(b_mem_stall)
   );

   // Shared memory path
   mem_arbiter i_arbiter (
      .clk(clk), .rst_n(rst_n),
      .a_mem_req(a_mem_req), .a_mem_rd(a_mem_rd), .a_mem_wr(a_mem_wr),
      .a_mem_addr(a_mem_addr), .a_mem_wdata(a_mem_wdata),
      .a_mem_stall(a_mem_stall), .a_mem_rdata(a_mem_rdata),
      .b_mem_req(b_mem_req), .b_mem_rd(b_mem_rd), .b_mem_wr(b_mem_wr),
      .b_mem_addr(b_mem_addr), .b_mem_wdata(b_mem_wdata),
      .b_mem_stall(b_mem_stall), .b_mem_rdata(b_mem_rdata),
      .rd(mem_rd), .wr(mem_wr), .addr(mem_addr), .data_in(mem_wdata),
      .data_out(mem_rdata), .stall(mem_stall)
   );

   four_bank_mem i_mem (
      .clk(clk), .rst_n(rst_n), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
      .data_in(mem_wdata), .data_out(mem_rdata), .stall(mem_stall)
   );

endmodule

`default_nettype wire

// File: bench/tb_mem_system.sv
//**************************************************
// Testbench for the two-client memory system
// Replays the transactions in bench/mem_testdata.txt on ports A and B
// Checks read data, cache_hit, stall, hit latency and the sticky err
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

   // Words per transaction line in the data file
   localparam int FIELDS  = 7;
   localparam int MAX_TXN = 64;
   // Request seen in cycle 0, done in cycle 2
   localparam int HIT_LAT = 2;

   logic        clk;
   logic        rst_n;
   logic [15:0] a_addr;
   logic [15:0] a_data_in;
   logic        a_rd;
   logic        a_wr;
   logic [15:0] a_data_out;
   logic        a_done;
   logic        a_stall;
   logic        a_cache_hit;
   logic        a_err;
   logic [15:0] b_addr;
   logic [15:0] b_data_in;
   logic        b_rd;
   logic        b_wr;
   logic [15:0] b_data_out;
   logic        b_done;
   logic        b_stall;
   logic        b_cache_hit;
   logic        b_err;

   // Transaction table, FIELDS words per line
   logic [15:0] td [FIELDS*MAX_TXN];
   int          n_txn;
   int          chk_cnt;
   int          err_cnt;
   int          seed;
   int          cycle = 0;
   int          cycle_limit;
   // Per-port bookkeeping, index 0 is port A
   logic        pend [2];
   int          txn_of [2];
   int          lat [2];
   logic        err_expected [2];
   logic        err_seen [2];

   mem_system_top i_dut (
      .clk(clk), .rst_n(rst_n),
      .a_addr(a_addr), .a_data_in(a_data_in), .a_rd(a_rd), .a_wr(a_wr),
      .a_data_out(a_data_out), .a_done(a_done), .a_stall(a_stall),
      .a_cache_hit(a_cache_hit), .a_err(a_err),
      .b_addr(b_addr), .b_data_in(b_data_in), .b_rd(b_rd), .b_wr(b_wr),
      .b_data_out(b_data_out), .b_done(b_done), .b_stall(b_stall),
      .b_cache_hit(b_cache_hit), .b_err(b_err)
   );

   always #5 clk = ~clk;

   function automatic string port_name(input int p);
      return (p == 0) ? "A" : "B";
   endfunction

   function automatic logic done_of(input int p);
      return (p == 0) ? a_done : b_done;
   endfunction

   function automatic logic err_of(input int p);
      return (p == 0) ? a_err : b_err;
   endfunction

   // Done ends a request, err ends an rd+wr request
   function automatic logic finished(input int p);
      logic [15:0] op;
      op = td[FIELDS*txn_of[p]+2];
      if (op == 16'h3) begin
         return err_of(p);
      end
      return done_of(p);
   endfunction

   // Raise the strobes of one line on its port
   task automatic start_request(input int t);
      int          p;
      logic [15:0] op;
      p  = (td[FIELDS*t+1] == 16'h0) ? 0 : 1;
      op = td[FIELDS*t+2];
      pend[p]   = 1'b1;
      txn_of[p] = t;
      lat[p]    = 0;
      if (op == 16'h3) begin
         err_expected[p] = 1'b1;
      end
      if (p == 0) begin
         a_addr    <= td[FIELDS*t+3];
         a_data_in <= td[FIELDS*t+4];
         a_rd      <= (op != 16'h1);
         a_wr      <= (op != 16'h0);
      end else begin
         b_addr    <= td[FIELDS*t+3];
         b_data_in <= td[FIELDS*t+4];
         b_rd      <= (op != 16'h1);
         b_wr      <= (op != 16'h0);
      end
   endtask

   task automatic check_response(input int p);
      int          t;
      logic [15:0] op;
      logic [15:0] data;
      logic        hit;
      t    = txn_of[p];
      op   = td[FIELDS*t+2];
      data = (p == 0) ? a_data_out : b_data_out;
      hit  = (p == 0) ? a_cache_hit : b_cache_hit;
      chk_cnt++;
      if (op == 16'h3) begin
         err_seen[p] = 1'b1;
      end else begin
         // Read data only, writes return nothing
         if (op == 16'h0 && data != td[FIELDS*t+5]) begin
            err_cnt++;
            $display("ERR %0t: port %s read 0x%04h gave 0x%04h, expected 0x%04h",
                     $time, port_name(p), td[FIELDS*t+3], data, td[FIELDS*t+5]);
         end
         if (hit != td[FIELDS*t+6][0]) begin
            err_cnt++;
            $display("ERR %0t: port %s access 0x%04h cache_hit %0b, expected %0b",
                     $time, port_name(p), td[FIELDS*t+3], hit, td[FIELDS*t+6][0]);
         end
         if (hit && lat[p] != HIT_LAT) begin
            err_cnt++;
            $display("ERR %0t: port %s hit on 0x%04h took %0d cycles, expected %0d",
                     $time, port_name(p), td[FIELDS*t+3], lat[p], HIT_LAT);
         end
      end
   endtask

   // Sample at the falling edge until every pending port is finished
   task automatic wait_responses();
      logic stall_now;
      logic stall_exp;
      while (pend[0] || pend[1]) begin
         @(negedge clk);
         for (int p = 0; p < 2; p++) begin
            // Stall runs from the cycle after the request up to done
            if (!err_expected[p]) begin
               stall_now = (p == 0) ? a_stall : b_stall;
               stall_exp = pend[p] && lat[p] >= 1;
               if (stall_now != stall_exp) begin
                  err_cnt++;
                  $display("ERR %0t: port %s stall %0b, expected %0b",
                           $time, port_name(p), stall_now, stall_exp);
               end
            end
            if (pend[p] && finished(p)) begin
               check_response(p);
               pend[p] = 1'b0;
            end
            lat[p]++;
         end
         // Release a finished port on the edge after its done
         @(posedge clk);
         // A failed port keeps a plain read up that it must never finish
         if (!pend[0]) begin
            a_rd <= err_seen[0];
            a_wr <= 1'b0;
         end
         if (!pend[1]) begin
            b_rd <= err_seen[1];
            b_wr <= 1'b0;
         end
      end
   endtask

   initial begin
      int t;
      int idle;
      clk       = 1'b0;
      rst_n     = 1'b0;
      a_addr    = '0;
      a_data_in = '0;
      a_rd      = 1'b0;
      a_wr      = 1'b0;
      b_addr    = '0;
      b_data_in = '0;
      b_rd      = 1'b0;
      b_wr      = 1'b0;
      seed      = 77;
      chk_cnt   = 0;
      err_cnt   = 0;
      for (int p = 0; p < 2; p++) begin
         pend[p]         = 1'b0;
         txn_of[p]       = 0;
         lat[p]          = 0;
         err_expected[p] = 1'b0;
         err_seen[p]     = 1'b0;
      end
      $readmemh("bench/mem_testdata.txt", td);
      // List ends at the first pair flag other than 0 or 1
      n_txn = 0;
      while (n_txn < MAX_TXN &&
             (td[FIELDS*n_txn] == 16'h0 || td[FIELDS*n_txn] == 16'h1)) begin
         n_txn++;
      end
      cycle_limit = 80 * n_txn + 200;
      if (n_txn == 0) begin
         err_cnt++;
         $display("No transactions could be read from bench/mem_testdata.txt");
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      t = 0;
      while (t < n_txn) begin
         idle = {$random(seed)} % 4;
         repeat (idle) @(posedge clk);
         @(posedge clk);
         start_request(t);
         // Paired line goes out on the same edge
         if (td[FIELDS*t] == 16'h1 && t + 1 < n_txn) begin
            start_request(t + 1);
            t = t + 2;
         end else begin
            t = t + 1;
         end
         wait_responses();
      end
      // Give the err monitor a few more cycles
      repeat (10) @(posedge clk);
      $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // err only after an rd+wr request, then sticky with no more done
   always @(negedge clk) begin
      if (rst_n) begin
         for (int p = 0; p < 2; p++) begin
            if (err_of(p) && !err_expected[p]) begin
               err_cnt++;
               $display("Port %s raised err without a request that has rd and wr together",
                        port_name(p));
            end
            if (err_seen[p] && !err_of(p)) begin
               err_cnt++;
               $display("Port %s dropped err before a reset", port_name(p));
            end
            if (err_seen[p] && done_of(p)) begin
               err_cnt++;
               $display("Port %s completed a request after its error", port_name(p));
            end
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
         $display("*** FAILED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: bench/mem_testdata.txt
// pair port op addr wdata exp_data exp_hit, all hex, port 0 is A and 1 is B
// op 0 read, 1 write, 3 rd and wr together; pair 1 issues with the next line
// Cold miss, then a hit on the same word
0 0 0 0100 0000 0000 0
0 0 0 0100 0000 0000 1
// Write miss, then hits on the written word and a neighbour
0 0 1 0208 1234 0000 0
0 0 0 0208 0000 1234 1
0 0 0 020c 0000 0000 1
// Dirty victim written back on a tag conflict
0 0 1 0300 beef 0000 0
0 0 0 0b00 0000 0000 0
0 0 0 0300 0000 beef 0
// Both ports miss together, then hit together
1 0 1 1000 5a5a 0000 0
0 1 1 9000 a5a5 0000 0
1 0 0 1000 0000 5a5a 1
0 1 0 9000 0000 a5a5 1
// Both ports evict dirty lines at once, then refetch them
1 0 0 1800 0000 0000 0
0 1 0 9800 0000 0000 0
1 0 0 1000 0000 5a5a 0
0 1 0 9000 0000 a5a5 0
// Port A error, port B keeps working
0 0 3 0100 0000 0000 0
0 1 0 9000 0000 a5a5 1
0 1 1 8010 7777 0000 0
0 1 0 8010 0000 7777 1
0 1 0 8012 0000 0000 1
0 1 0 9800 0000 0000 0
// End of list
f 0 0 0000 0000 0000 0

// File: verilog.f
hdl/mem_sys_pkg.sv
hdl/cache_array.sv
hdl/cache_ctrl.sv
hdl/mem_arbiter.sv
hdl/four_bank_mem.sv
hdl/mem_system_top.sv
bench/tb_mem_system.sv

// File: Makefile
# Verilator build and run of the two-client memory system testbench
TOP := tb_mem_system

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
